/* tb.f */
+incdir+sim
common/id_pkg.sv
decode/id_opcode_class.sv
decode/id_field_select.sv
source/id_stage_reg.sv
decode/stg_id.sv
sim/tb_stg_id.sv

/* Bender.yml */
package:
  name: stg_id

sources:
  - common/id_pkg.sv
  - decode/id_opcode_class.sv
  - decode/id_field_select.sv
  - source/id_stage_reg.sv
  - decode/stg_id.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_stg_id.sv

/* sim/id_ref_model.svh */
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// Expected stage contents for one accepted (pc, instr) pair
function automatic void id_ref_model(
    input  logic [id_pkg::pc_w-1:0]    pc_in,
    input  logic [id_pkg::instr_w-1:0] instr_in,
    output id_pkg::id_ctrl_t           ctrl,
    output id_pkg::id_field_t          fld
);
    id_pkg::opc_t op;
    logic [19:0]  row;
    logic [10:0]  flags;
    logic [4:0]   imm_width;
    logic [3:0]   cc_lsb;

    op = instr_in[23:16];

    // Flag bits sgn imm, gp_we gp_tgt gp_src gp_hi, sr_we sr_tgt sr_src, flags lr
    // Then immediate width and cc low bit, where 0 means none
    case (op)
        8'h00, 8'h01, 8'h02, 8'h03: row = {11'b00_1110_000_00, 5'd0, 4'd0};
        8'h04:                      row = {11'b00_0110_000_00, 5'd0, 4'd0};
        8'h05:                      row = {11'b00_1110_001_10, 5'd0, 4'd4};
        8'h10, 8'h11, 8'h12, 8'h13: row = {11'b01_1100_000_00, 5'd12, 4'd0};
        8'h14:                      row = {11'b01_0100_000_00, 5'd12, 4'd0};
        8'h20, 8'h21:               row = {11'b10_1110_000_00, 5'd0, 4'd0};
        8'h22:                      row = {11'b10_0110_000_00, 5'd0, 4'd0};
        8'h30, 8'h31:               row = {11'b11_1100_000_00, 5'd12, 4'd0};
        8'h32:                      row = {11'b11_1100_001_10, 5'd0, 4'd8};
        8'h40:                      row = {11'b00_1100_000_00, 5'd0, 4'd0};
        8'h41:                      row = {11'b00_0011_000_00, 5'd0, 4'd0};
        8'h50:                      row = {11'b11_1100_000_00, 5'd10, 4'd0};
        8'h51:                      row = {11'b11_0011_000_00, 5'd10, 4'd0};
        8'h70:                      row = {11'b00_0000_001_10, 5'd0, 4'd10};
        8'h71:                      row = {11'b01_0000_001_10, 5'd12, 4'd12};
        8'h72:                      row = {11'b10_0100_001_10, 5'd0, 4'd8};
        8'h73:                      row = {11'b11_0000_001_10, 5'd12, 4'd12};
        8'h74:                      row = {11'b11_0000_001_10, 5'd16, 4'd0};
        8'hF0:                      row = {11'b00_0000_111_00, 5'd0, 4'd0};
        8'hF1:                      row = {11'b11_0000_110_00, 5'd14, 4'd0};
        8'hF2:                      row = {11'b11_0000_111_00, 5'd12, 4'd0};
        8'hF3:                      row = {11'b11_0000_011_00, 5'd12, 4'd0};
        8'hF4:                      row = {11'b11_0000_001_10, 5'd10, 4'd10};
        8'hF5:                      row = {11'b01_0000_110_01, 5'd0, 4'd0};
        8'hF6:                      row = {11'b00_0000_000_01, 5'd0, 4'd0};
        default:                    row = '0;
    endcase

    flags     = row[19:9];
    imm_width = row[8:4];
    cc_lsb    = row[3:0];

    ctrl.pc         = pc_in;
    ctrl.opcode     = op;
    ctrl.sgn_en     = flags[10];
    ctrl.imm_en     = flags[9];
    ctrl.tgt_gp_we  = flags[8];
    ctrl.has_src_gp = flags[6];
    ctrl.tgt_sr_we  = flags[4];
    ctrl.has_src_sr = flags[2];

    fld.tgt_gp = flags[7] ? instr_in[15:12] : 4'h0;
    fld.src_gp = !flags[6] ? 4'h0 : (flags[5] ? instr_in[13:10] : instr_in[11:8]);
    fld.tgt_sr = flags[0] ? 2'd1 : (flags[3] ? instr_in[15:14] : 2'd0);
    fld.src_sr = flags[1] ? 2'd2 : (flags[2] ? instr_in[13:12] : 2'd0);
    fld.cc     = (cc_lsb == 4'd0) ? 4'h0 : instr_in[cc_lsb +: 4];
    fld.imm10  = (imm_width == 5'd10) ? instr_in[9:0] : '0;
    fld.imm12  = (imm_width == 5'd12) ? instr_in[11:0] : '0;
    fld.imm14  = (imm_width == 5'd14) ? instr_in[13:0] : '0;
    fld.imm16  = (imm_width == 5'd16) ? instr_in[15:0] : '0;
endfunction

`endif

/* sim/tb_stg_id.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_stg_id;
    import id_pkg::*;

    localparam int n_directed     = 33 * 3;
    localparam int n_forced       = 10 * 2;
    localparam int n_undef        = 40;
    localparam int n_stall        = 60;
    localparam int n_flush        = 60;
    localparam int n_resume       = 10;
    localparam int stim_cycles    = 2 + n_directed + n_forced + n_undef + n_stall
                                    + n_flush + n_resume;
    localparam int timeout_cycles = 2 * stim_cycles + 20;

    logic               iw_clk = 1'b0;
    logic               iw_rst;
    logic [pc_w-1:0]    pc;
    logic [instr_w-1:0] instr;
    logic               flush;
    logic               stall;

    logic [pc_w-1:0]    pc_q;
    opc_t               opc;
    logic               sgn_en;
    logic               imm_en;
    logic [imm10_w-1:0] imm10_val;
    logic [imm12_w-1:0] imm12_val;
    logic [imm14_w-1:0] imm14_val;
    logic [imm16_w-1:0] imm16_val;
    cc_t                cc;
    logic               has_src_gp;
    gp_idx_t            src_gp;
    gp_idx_t            tgt_gp;
    logic               tgt_gp_we;
    logic               has_src_sr;
    sr_idx_t            src_sr;
    sr_idx_t            tgt_sr;
    logic               tgt_sr_we;

    // Model of what the stage register holds after the next edge
    id_ctrl_t    exp_ctrl;
    id_field_t   exp_fld;
    id_ctrl_t    exp_ctrl_q[$];
    id_field_t   exp_field_q[$];
    logic        checking = 1'b0;
    int          cycle_cnt = 0;

    opc_t defined_ops [0:32] = '{
        opc_movur, opc_addur, opc_subur, opc_andur, opc_cmpur, opc_mccur,
        opc_movui, opc_addui, opc_andui, opc_shlui, opc_cmpui,
        opc_addsr, opc_subsr, opc_cmpsr, opc_movsi, opc_addsi, opc_mccsi,
        opc_ldur, opc_stur, opc_ldso, opc_stso,
        opc_jccur, opc_jccui, opc_bccsr, opc_bccso, opc_balso,
        opc_srmovur, opc_sraddsi, opc_srldso, opc_srstso, opc_srjccso, opc_swi,
        opc_sret
    };

    // Flag readers plus the two opcodes that target the link register
    opc_t forced_ops [0:9] = '{
        opc_jccur, opc_jccui, opc_bccsr, opc_bccso, opc_balso,
        opc_srjccso, opc_mccur, opc_mccsi, opc_swi, opc_sret
    };

    `include "id_ref_model.svh"

    stg_id UUT (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .pc         (pc),
        .instr      (instr),
        .flush      (flush),
        .stall      (stall),
        .pc_q       (pc_q),
        .opc        (opc),
        .sgn_en     (sgn_en),
        .imm_en     (imm_en),
        .imm10_val  (imm10_val),
        .imm12_val  (imm12_val),
        .imm14_val  (imm14_val),
        .imm16_val  (imm16_val),
        .cc         (cc),
        .has_src_gp (has_src_gp),
        .src_gp     (src_gp),
        .tgt_gp     (tgt_gp),
        .tgt_gp_we  (tgt_gp_we),
        .has_src_sr (has_src_sr),
        .src_sr     (src_sr),
        .tgt_sr     (tgt_sr),
        .tgt_sr_we  (tgt_sr_we)
    );

    always #2 iw_clk = ~iw_clk;

    always @(posedge iw_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "Output mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs(input id_ctrl_t ec, input id_field_t ef);
        check_value("pc_q", pc_q, ec.pc);
        check_value("opc", opc, ec.opcode);
        check_value("sgn_en", sgn_en, ec.sgn_en);
        check_value("imm_en", imm_en, ec.imm_en);
        check_value("has_src_gp", has_src_gp, ec.has_src_gp);
        check_value("tgt_gp_we", tgt_gp_we, ec.tgt_gp_we);
        check_value("has_src_sr", has_src_sr, ec.has_src_sr);
        check_value("tgt_sr_we", tgt_sr_we, ec.tgt_sr_we);
        check_value("cc", cc, ef.cc);
        check_value("src_gp", src_gp, ef.src_gp);
        check_value("tgt_gp", tgt_gp, ef.tgt_gp);
        check_value("src_sr", src_sr, ef.src_sr);
        check_value("tgt_sr", tgt_sr, ef.tgt_sr);
        check_value("imm10_val", imm10_val, ef.imm10);
        check_value("imm12_val", imm12_val, ef.imm12);
        check_value("imm14_val", imm14_val, ef.imm14);
        check_value("imm16_val", imm16_val, ef.imm16);
    endtask

    function automatic logic opcode_is_defined(input opc_t op);
        int i;
        for (i = 0; i < 33; i++) begin
            if (defined_ops[i] == op) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic opc_t random_undefined_opc();
        opc_t op;
        op = 8'($urandom);
        while (opcode_is_defined(op)) begin
            op = 8'($urandom);
        end
        return op;
    endfunction

    // Half defined opcodes, half any byte
    function automatic logic [instr_w-1:0] random_instr();
        opc_t op;
        if ($urandom_range(1) == 0) begin
            op = defined_ops[$urandom_range(32)];
        end else begin
            op = 8'($urandom);
        end
        return {op, 16'($urandom)};
    endfunction

    // Called at a falling edge, returns at the next one
    task automatic drive_cycle(input logic [pc_w-1:0] p, input logic [instr_w-1:0] w,
                               input logic fl, input logic st);
        id_ctrl_t  nc;
        id_field_t nf;
        pc    = p;
        instr = w;
        flush = fl;
        stall = st;
        if (fl) begin
            exp_ctrl = '0;
            exp_fld  = '0;
        end else if (!st) begin
            id_ref_model(p, w, nc, nf);
            exp_ctrl = nc;
            exp_fld  = nf;
        end
        exp_ctrl_q.push_back(exp_ctrl);
        exp_field_q.push_back(exp_fld);
        @(negedge iw_clk);
    endtask

    initial begin : output_compare
        id_ctrl_t  ec;
        id_field_t ef;
        wait (checking);
        forever begin
            @(posedge iw_clk);
            #1;
            if (exp_ctrl_q.size() != 0) begin
                ec = exp_ctrl_q.pop_front();
                ef = exp_field_q.pop_front();
                compare_outputs(ec, ef);
            end
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= timeout_cycles);
        $display("TESTBENCH FAILED");
        $fatal(1, "Timeout: run did not finish within %0d clock cycles", timeout_cycles);
    end

    initial begin : stimulus
        int i;
        int k;
        void'($urandom(32'h544));
        iw_rst   = 1'b1;
        pc       = '0;
        instr    = '0;
        flush    = 1'b0;
        stall    = 1'b0;
        exp_ctrl = '0;
        exp_fld  = '0;
        repeat (2) @(posedge iw_clk);
        @(negedge iw_clk);
        iw_rst = 1'b0;
        compare_outputs('0, '0);
        checking = 1'b1;

        for (i = 0; i < 33; i++) begin
            for (k = 0; k < 3; k++) begin
                drive_cycle(16'($urandom), {defined_ops[i], 16'($urandom)}, 1'b0, 1'b0);
            end
        end
        // Bits 15..12 at both extremes
        for (i = 0; i < 10; i++) begin
            drive_cycle(16'($urandom), {forced_ops[i], 4'hF, 12'($urandom)}, 1'b0, 1'b0);
            drive_cycle(16'($urandom), {forced_ops[i], 4'h0, 12'($urandom)}, 1'b0, 1'b0);
        end
        for (i = 0; i < n_undef; i++) begin
            drive_cycle(16'($urandom), {random_undefined_opc(), 16'($urandom)}, 1'b0, 1'b0);
        end
        for (i = 0; i < n_stall; i++) begin
            drive_cycle(16'($urandom), random_instr(), 1'b0, $urandom_range(3) == 0);
        end
        // Flush and stall drawn apart, so both together occur too
        for (i = 0; i < n_flush; i++) begin
            drive_cycle(16'($urandom), random_instr(), $urandom_range(4) == 0,
                        $urandom_range(3) == 0);
        end
        for (i = 0; i < n_resume; i++) begin
            drive_cycle(16'($urandom), random_instr(), 1'b0, 1'b0);
        end

        @(posedge iw_clk);
        #2;
        if (exp_ctrl_q.size() != 0) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "%0d predictions were never compared", exp_ctrl_q.size());
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* decode/stg_id.sv */
`timescale 1ns/100ps
`default_nettype none

module stg_id (
    input  wire                        iw_clk,
    input  wire                        iw_rst,
    input  wire [id_pkg::pc_w-1:0]     pc,
    input  wire [id_pkg::instr_w-1:0]  instr,
    input  wire                        flush,
    input  wire                        stall,
    output logic [id_pkg::pc_w-1:0]    pc_q,
    output id_pkg::opc_t               opc,
    output logic                       sgn_en,
    output logic                       imm_en,
    output logic [id_pkg::imm10_w-1:0] imm10_val,
    output logic [id_pkg::imm12_w-1:0] imm12_val,
    output logic [id_pkg::imm14_w-1:0] imm14_val,
    output logic [id_pkg::imm16_w-1:0] imm16_val,
    output id_pkg::cc_t                cc,
    output logic                       has_src_gp,
    output id_pkg::gp_idx_t            src_gp,
    output id_pkg::gp_idx_t            tgt_gp,
    output logic                       tgt_gp_we,
    output logic                       has_src_sr,
    output id_pkg::sr_idx_t            src_sr,
    output id_pkg::sr_idx_t            tgt_sr,
    output logic                       tgt_sr_we
);
    import id_pkg::*;

    opc_t      instr_opc;
    logic      dec_sgn_en;
    logic      dec_imm_en;
    logic      dec_tgt_gp_we;
    logic      dec_has_tgt_gp;
    logic      dec_has_src_gp;
    logic      dec_src_gp_hi;
    logic      dec_tgt_sr_we;
    logic      dec_has_tgt_sr;
    logic      dec_has_src_sr;
    logic      dec_uses_flags;
    logic      dec_sr_force_lr;
    imm_kind_t dec_imm_kind;
    cc_pos_t   dec_cc_pos;

    id_ctrl_t  ctrl_d;
    id_ctrl_t  ctrl_q;
    id_field_t field_d;
    id_field_t field_q;

    assign instr_opc = instr[instr_w-1 -: opc_w];

    id_opcode_class u_class (
        .opc         (instr_opc),
        .sgn_en      (dec_sgn_en),
        .imm_en      (dec_imm_en),
        .tgt_gp_we   (dec_tgt_gp_we),
        .has_tgt_gp  (dec_has_tgt_gp),
        .has_src_gp  (dec_has_src_gp),
        .src_gp_hi   (dec_src_gp_hi),
        .tgt_sr_we   (dec_tgt_sr_we),
        .has_tgt_sr  (dec_has_tgt_sr),
        .has_src_sr  (dec_has_src_sr),
        .uses_flags  (dec_uses_flags),
        .sr_force_lr (dec_sr_force_lr),
        .imm_kind    (dec_imm_kind),
        .cc_pos      (dec_cc_pos)
    );

    id_field_select u_select (
        .instr       (instr),
        .has_src_gp  (dec_has_src_gp),
        .src_gp_hi   (dec_src_gp_hi),
        .has_tgt_gp  (dec_has_tgt_gp),
        .has_src_sr  (dec_has_src_sr),
        .uses_flags  (dec_uses_flags),
        .has_tgt_sr  (dec_has_tgt_sr),
        .sr_force_lr (dec_sr_force_lr),
        .imm_kind    (dec_imm_kind),
        .cc_pos      (dec_cc_pos),
        .src_gp      (field_d.src_gp),
        .tgt_gp      (field_d.tgt_gp),
        .src_sr      (field_d.src_sr),
        .tgt_sr      (field_d.tgt_sr),
        .cc          (field_d.cc),
        .imm10_val   (field_d.imm10),
        .imm12_val   (field_d.imm12),
        .imm14_val   (field_d.imm14),
        .imm16_val   (field_d.imm16)
    );

    assign ctrl_d = '{
        pc:         pc,
        opcode:     instr_opc,
        sgn_en:     dec_sgn_en,
        imm_en:     dec_imm_en,
        has_src_gp: dec_has_src_gp,
        tgt_gp_we:  dec_tgt_gp_we,
        has_src_sr: dec_has_src_sr,
        tgt_sr_we:  dec_tgt_sr_we
    };

    id_stage_reg #(
        .payload_t (id_ctrl_t)
    ) u_ctrl_reg (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .flush  (flush),
        .stall  (stall),
        .d      (ctrl_d),
        .q      (ctrl_q)
    );

    id_stage_reg #(
        .payload_t (id_field_t)
    ) u_field_reg (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .flush  (flush),
        .stall  (stall),
        .d      (field_d),
        .q      (field_q)
    );

    assign pc_q       = ctrl_q.pc;
    assign opc        = ctrl_q.opcode;
    assign sgn_en     = ctrl_q.sgn_en;
    assign imm_en     = ctrl_q.imm_en;
    assign has_src_gp = ctrl_q.has_src_gp;
    assign tgt_gp_we  = ctrl_q.tgt_gp_we;
    assign has_src_sr = ctrl_q.has_src_sr;
    assign tgt_sr_we  = ctrl_q.tgt_sr_we;

    assign cc         = field_q.cc;
    assign src_gp     = field_q.src_gp;
    assign tgt_gp     = field_q.tgt_gp;
    assign src_sr     = field_q.src_sr;
    assign tgt_sr     = field_q.tgt_sr;
    assign imm10_val  = field_q.imm10;
    assign imm12_val  = field_q.imm12;
    assign imm14_val  = field_q.imm14;
    assign imm16_val  = field_q.imm16;

endmodule

`default_nettype wire

/* source/id_stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module id_stage_reg #(
    parameter type payload_t = logic
) (
    input  wire           iw_clk,
    input  wire           iw_rst,
    input  wire           flush,
    input  wire           stall,
    input  wire payload_t d,
    output payload_t      q
);

    // Flush wins over stall
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* decode/id_field_select.sv */
`timescale 1ns/100ps
`default_nettype none

module id_field_select (
    input  wire [id_pkg::instr_w-1:0]  instr,
    input  wire                        has_src_gp,
    input  wire                        src_gp_hi,
    input  wire                        has_tgt_gp,
    input  wire                        has_src_sr,
    input  wire                        uses_flags,
    input  wire                        has_tgt_sr,
    input  wire                        sr_force_lr,
    input  wire id_pkg::imm_kind_t     imm_kind,
    input  wire id_pkg::cc_pos_t       cc_pos,
    output id_pkg::gp_idx_t            src_gp,
    output id_pkg::gp_idx_t            tgt_gp,
    output id_pkg::sr_idx_t            src_sr,
    output id_pkg::sr_idx_t            tgt_sr,
    output id_pkg::cc_t                cc,
    output logic [id_pkg::imm10_w-1:0] imm10_val,
    output logic [id_pkg::imm12_w-1:0] imm12_val,
    output logic [id_pkg::imm14_w-1:0] imm14_val,
    output logic [id_pkg::imm16_w-1:0] imm16_val
);
    import id_pkg::*;

    assign tgt_gp = has_tgt_gp ? instr[15:12] : '0;

    // Stores keep the data register next to the base field
    always_comb begin
        if (!has_src_gp) begin
            src_gp = '0;
        end else if (src_gp_hi) begin
            src_gp = instr[13:10];
        end else begin
            src_gp = instr[11:8];
        end
    end

    // swi and sret always address the link register
    always_comb begin
        if (sr_force_lr) begin
            tgt_sr = sr_idx_lr;
        end else if (has_tgt_sr) begin
            tgt_sr = instr[15:14];
        end else begin
            tgt_sr = '0;
        end
    end

    always_comb begin
        if (uses_flags) begin
            src_sr = sr_idx_fl;
        end else if (has_src_sr) begin
            src_sr = instr[13:12];
        end else begin
            src_sr = '0;
        end
    end

    // Only one slice is live, the rest read as zero
    assign imm10_val = (imm_kind == imm_10) ? instr[imm10_w-1:0] : '0;
    assign imm12_val = (imm_kind == imm_12) ? instr[imm12_w-1:0] : '0;
    assign imm14_val = (imm_kind == imm_14) ? instr[imm14_w-1:0] : '0;
    assign imm16_val = (imm_kind == imm_16) ? instr[imm16_w-1:0] : '0;

    always_comb begin
        case (cc_pos)
            cc_15_12: cc = instr[15:12];
            cc_13_10: cc = instr[13:10];
            cc_11_8:  cc = instr[11:8];
            cc_7_4:   cc = instr[7:4];
            default:  cc = '0;
        endcase
    end

endmodule

`default_nettype wire

/* decode/id_opcode_class.sv */
`timescale 1ns/100ps
`default_nettype none

module id_opcode_class (
    input  wire id_pkg::opc_t opc,
    output logic              sgn_en,
    output logic              imm_en,
    output logic              tgt_gp_we,
    output logic              has_tgt_gp,
    output logic              has_src_gp,
    output logic              src_gp_hi,
    output logic              tgt_sr_we,
    output logic              has_tgt_sr,
    output logic              has_src_sr,
    output logic              uses_flags,
    output logic              sr_force_lr,
    output id_pkg::imm_kind_t imm_kind,
    output id_pkg::cc_pos_t   cc_pos
);
    import id_pkg::*;

    logic [3:0] opclass;
    logic       defined;

    assign opclass = opc[opc_w-1 -: 4];

    // Class terms below only count for opcodes in the table
    assign defined = opc inside {
        opc_movur, opc_addur, opc_subur, opc_andur, opc_cmpur, opc_mccur,
        opc_movui, opc_addui, opc_andui, opc_shlui, opc_cmpui,
        opc_addsr, opc_subsr, opc_cmpsr, opc_movsi, opc_addsi, opc_mccsi,
        opc_ldur, opc_stur, opc_ldso, opc_stso,
        opc_jccur, opc_jccui, opc_bccsr, opc_bccso, opc_balso,
        opc_srmovur, opc_sraddsi, opc_srldso, opc_srstso, opc_srjccso,
        opc_swi, opc_sret
    };

    assign sgn_en = (defined && (opclass inside {4'h2, 4'h3, 4'h5})) ||
                    (opc inside {opc_bccsr, opc_bccso, opc_balso, opc_srjccso,
                                 opc_sraddsi, opc_srstso, opc_srldso});

    assign imm_en = (defined && (opclass inside {4'h1, 4'h3, 4'h5})) ||
                    (opc inside {opc_jccui, opc_bccso, opc_balso, opc_swi, opc_srjccso,
                                 opc_sraddsi, opc_srstso, opc_srldso});

    assign tgt_gp_we = opc inside {
        opc_movur, opc_addur, opc_subur, opc_andur, opc_ldur, opc_ldso,
        opc_addsr, opc_subsr, opc_movui, opc_addui, opc_andui, opc_shlui,
        opc_movsi, opc_addsi, opc_mccur, opc_mccsi
    };

    // Compares and bccsr name a GP register without writing it
    assign has_tgt_gp = tgt_gp_we ||
                        (opc inside {opc_cmpur, opc_cmpsr, opc_cmpui, opc_bccsr});

    assign has_src_gp = opc inside {
        opc_movur, opc_addur, opc_subur, opc_andur, opc_cmpur, opc_stur,
        opc_stso, opc_addsr, opc_subsr, opc_cmpsr, opc_mccur
    };

    assign src_gp_hi = opc inside {opc_stur, opc_stso};

    assign tgt_sr_we  = opc inside {opc_srmovur, opc_sraddsi, opc_srldso, opc_swi};
    assign has_tgt_sr = tgt_sr_we || (opc == opc_srstso);

    // Branches and conditional moves read the flags register
    assign uses_flags = (defined && (opclass == 4'h7)) ||
                        (opc inside {opc_srjccso, opc_mccur, opc_mccsi});

    assign has_src_sr = uses_flags ||
                        (opc inside {opc_srmovur, opc_srjccso, opc_srldso, opc_srstso});

    assign sr_force_lr = opc inside {opc_swi, opc_sret};

    always_comb begin
        case (opc)
            opc_movui, opc_addui, opc_andui, opc_shlui, opc_cmpui,
            opc_movsi, opc_addsi, opc_jccui, opc_bccso,
            opc_srstso, opc_srldso:              imm_kind = imm_12;
            opc_sraddsi:                         imm_kind = imm_14;
            opc_srjccso, opc_ldso, opc_stso:     imm_kind = imm_10;
            opc_balso:                           imm_kind = imm_16;
            default:                             imm_kind = imm_none;
        endcase
    end

    always_comb begin
        case (opc)
            opc_jccur, opc_srjccso: cc_pos = cc_13_10;
            opc_jccui, opc_bccso:   cc_pos = cc_15_12;
            opc_bccsr, opc_mccsi:   cc_pos = cc_11_8;
            opc_mccur:              cc_pos = cc_7_4;
            default:                cc_pos = cc_none;
        endcase
    end

endmodule

`default_nettype wire

/* common/id_pkg.sv */
`default_nettype none

package id_pkg;

    localparam int unsigned instr_w = 24;
    localparam int unsigned pc_w    = 16;
    localparam int unsigned opc_w   = 8;

    localparam int unsigned imm10_w = 10;
    localparam int unsigned imm12_w = 12;
    localparam int unsigned imm14_w = 14;
    localparam int unsigned imm16_w = 16;

    // Opcode sits in the top byte, class in its upper nibble
    typedef logic [opc_w-1:0] opc_t;
    typedef logic [3:0]       gp_idx_t;
    typedef logic [1:0]       sr_idx_t;
    typedef logic [3:0]       cc_t;

    localparam sr_idx_t sr_idx_lr = 2'd1;
    localparam sr_idx_t sr_idx_fl = 2'd2;

    // Class 0 register to register unsigned
    localparam opc_t opc_movur = 8'h00;
    localparam opc_t opc_addur = 8'h01;
    localparam opc_t opc_subur = 8'h02;
    localparam opc_t opc_andur = 8'h03;
    localparam opc_t opc_cmpur = 8'h04;
    localparam opc_t opc_mccur = 8'h05;

    // Class 1 unsigned immediate
    localparam opc_t opc_movui = 8'h10;
    localparam opc_t opc_addui = 8'h11;
    localparam opc_t opc_andui = 8'h12;
    localparam opc_t opc_shlui = 8'h13;
    localparam opc_t opc_cmpui = 8'h14;

    // Classes 2 and 3 signed forms
    localparam opc_t opc_addsr = 8'h20;
    localparam opc_t opc_subsr = 8'h21;
    localparam opc_t opc_cmpsr = 8'h22;
    localparam opc_t opc_movsi = 8'h30;
    localparam opc_t opc_addsi = 8'h31;
    localparam opc_t opc_mccsi = 8'h32;

    // Loads and stores
    localparam opc_t opc_ldur  = 8'h40;
    localparam opc_t opc_stur  = 8'h41;
    localparam opc_t opc_ldso  = 8'h50;
    localparam opc_t opc_stso  = 8'h51;

    // Control flow
    localparam opc_t opc_jccur = 8'h70;
    localparam opc_t opc_jccui = 8'h71;
    localparam opc_t opc_bccsr = 8'h72;
    localparam opc_t opc_bccso = 8'h73;
    localparam opc_t opc_balso = 8'h74;

    // Special registers and traps
    localparam opc_t opc_srmovur  = 8'hF0;
    localparam opc_t opc_sraddsi  = 8'hF1;
    localparam opc_t opc_srldso   = 8'hF2;
    localparam opc_t opc_srstso   = 8'hF3;
    localparam opc_t opc_srjccso  = 8'hF4;
    localparam opc_t opc_swi      = 8'hF5;
    localparam opc_t opc_sret     = 8'hF6;

    typedef enum logic [2:0] {
        imm_none,
        imm_10,
        imm_12,
        imm_14,
        imm_16
    } imm_kind_t;

    // Named after the instruction bits holding the condition
    typedef enum logic [2:0] {
        cc_none,
        cc_15_12,
        cc_13_10,
        cc_11_8,
        cc_7_4
    } cc_pos_t;

    typedef struct packed {
        logic [pc_w-1:0] pc;
        opc_t            opcode;
        logic            sgn_en;
        logic            imm_en;
        logic            has_src_gp;
        logic            tgt_gp_we;
        logic            has_src_sr;
        logic            tgt_sr_we;
    } id_ctrl_t;

    typedef struct packed {
        cc_t                cc;
        gp_idx_t            src_gp;
        gp_idx_t            tgt_gp;
        sr_idx_t            src_sr;
        sr_idx_t            tgt_sr;
        logic [imm10_w-1:0] imm10;
        logic [imm12_w-1:0] imm12;
        logic [imm14_w-1:0] imm14;
        logic [imm16_w-1:0] imm16;
    } id_field_t;

endpackage

`default_nettype wire
